//--- hw/fpu_pkg.sv
package fpu_pkg;

    // IEEE-754 single precision format
    localparam int EXP_W    = 8;
    localparam int FRAC_W   = 23;
    localparam int EXP_BIAS = 127;
    localparam int SIG_W    = FRAC_W + 1;   // with hidden bit

    // 32-bit integer magnitude + guard, round, sticky, plus carry headroom
    localparam int EXT_W    = 35;

    typedef logic [31:0] fp_word_t;                 // ieee word or int operand
    typedef logic signed [EXP_W+1:0] exp_t;         // biased, room for over/underflow
    typedef logic [EXT_W-1:0] ext_sig_t;            // working significand

    // function codes, same encoding as the old ALU
    typedef enum logic [3:0] {
        FADD     = 4'b1011,
        FSUB     = 4'b1100,
        FCVT_S_W = 4'b1110
    } fpu_op_e;

    typedef enum logic [2:0] {
        RNE        = 3'b000,
        RTZ        = 3'b001,
        RDN        = 3'b010,
        RUP        = 3'b011,
        RMM_AS_RNE = 3'b111     // rmm handled as nearest-even
    } round_mode_e;

    typedef struct packed {
        fpu_op_e     op;
        round_mode_e rm;
        fp_word_t    a;         // minuend for fsub, integer for fcvt
        fp_word_t    b;
    } fpu_req_t;

    // stage 1 output, hidden bit sits at EXT_W-2
    typedef struct packed {
        logic     sign;
        exp_t     exp;
        ext_sig_t sig;
        logic     zero;
    } prenorm_t;

    // stage 2 output, significand followed by guard, round, sticky
    typedef struct packed {
        logic             sign;
        exp_t             exp;
        logic [SIG_W+2:0] sig;
        logic             zero;
    } norm_t;

    typedef struct packed {
        logic        valid;
        round_mode_e rm;
    } stage_ctl_t;

endpackage

//--- hw/fp_addsub.sv
module fp_addsub (
    input  fpu_pkg::fp_word_t a,
    input  fpu_pkg::fp_word_t b,
    input  logic              sub,
    output fpu_pkg::prenorm_t result
);
    import fpu_pkg::*;

    localparam int LOW_W = EXT_W - SIG_W - 1;   // bits below the significand

    logic [EXP_W-1:0]   exp_a;
    logic [EXP_W-1:0]   exp_b;
    logic [SIG_W-1:0]   sig_a;
    logic [SIG_W-1:0]   sig_b;
    logic               sign_a;
    logic               sign_b;     // effective sign, flipped for fsub
    logic               swap;
    logic [EXP_W-1:0]   exp_big;
    logic [EXP_W-1:0]   exp_small;
    logic [SIG_W-1:0]   sig_big;
    logic [SIG_W-1:0]   sig_small;
    logic               sign_big;
    logic [EXP_W-1:0]   exp_diff;
    logic [5:0]         shamt;
    ext_sig_t           big_ext;
    ext_sig_t           small_ext;
    logic [2*EXT_W-1:0] align;
    logic               sticky;
    ext_sig_t           small_aligned;
    logic               eff_sub;
    ext_sig_t           sum;

    // unpack, a zero exponent means a zero operand here
    assign exp_a  = a[FRAC_W +: EXP_W];
    assign exp_b  = b[FRAC_W +: EXP_W];
    assign sig_a  = {|exp_a, a[FRAC_W-1:0]};
    assign sig_b  = {|exp_b, b[FRAC_W-1:0]};
    assign sign_a = a[31];
    assign sign_b = b[31] ^ sub;

    // order by magnitude, exponent and fraction compare as one field
    assign swap = b[30:0] > a[30:0];

    assign exp_big   = swap ? exp_b : exp_a;
    assign exp_small = swap ? exp_a : exp_b;
    assign sig_big   = swap ? sig_b : sig_a;
    assign sig_small = swap ? sig_a : sig_b;
    assign sign_big  = swap ? sign_b : sign_a;

    assign exp_diff = exp_big - exp_small;

    // beyond 63 everything lands in the sticky part anyway
    assign shamt = (exp_diff > 8'd63) ? 6'd63 : exp_diff[5:0];

    assign big_ext   = {1'b0, sig_big, {LOW_W{1'b0}}};
    assign small_ext = {1'b0, sig_small, {LOW_W{1'b0}}};

    // lower half catches the bits shifted out
    assign align  = {small_ext, {EXT_W{1'b0}}} >> shamt;
    assign sticky = |align[EXT_W-1:0];

    assign small_aligned = align[2*EXT_W-1:EXT_W] | ext_sig_t'(sticky);    // jam sticky

    assign eff_sub = sign_a ^ sign_b;

    // big >= small, so the difference never goes negative
    assign sum = eff_sub ? (big_ext - small_aligned) : (big_ext + small_aligned);

    always_comb begin
        result.zero = (sum == '0);
        result.sign = result.zero ? 1'b0 : sign_big;    // exact zero is +0
        result.exp  = exp_t'({2'b00, exp_big});
        result.sig  = sum;
    end

endmodule

//--- hw/fp_normalize.sv
module fp_normalize (
    input  fpu_pkg::prenorm_t in,
    output fpu_pkg::norm_t    out
);
    import fpu_pkg::*;

    // top of the shifted significand, then guard and round below it
    localparam int TOP_LSB = EXT_W - SIG_W;     // 11
    localparam int G_POS   = TOP_LSB - 1;
    localparam int R_POS   = TOP_LSB - 2;

    logic [5:0] lz;
    ext_sig_t   shifted;
    logic       guard;
    logic       rnd;
    logic       sticky;

    // leading zero count over the whole working significand
    always_comb begin
        lz = 6'(EXT_W - 1);
        for (int i = 0; i < EXT_W; i++) begin
            if (in.sig[i]) begin
                lz = 6'(EXT_W - 1 - i);     // highest set bit wins
            end
        end
    end

    /*
     * The leading one is moved to the MSB of the working significand.
     * A carry out of the add already sits there (lz = 0, exponent +1),
     * a result already normal sits one below (lz = 1, exponent kept),
     * and cancellation or an integer needs a longer left shift.
     */
    assign shifted = in.sig << lz;

    assign guard  = shifted[G_POS];
    assign rnd    = shifted[R_POS];
    assign sticky = |shifted[R_POS-1:0];    // or of everything left over

    always_comb begin
        out.sign = in.sign;
        out.zero = in.zero;
        out.exp  = in.exp + exp_t'(1) - exp_t'({4'b0000, lz});
        out.sig  = {shifted[EXT_W-1:TOP_LSB], guard, rnd, sticky};
    end

endmodule

//--- hw/fp_round.sv
module fp_round (
    input  fpu_pkg::norm_t       in,
    input  fpu_pkg::round_mode_e rm,
    output fpu_pkg::fp_word_t    y
);
    import fpu_pkg::*;

    logic [SIG_W-1:0]  mant;
    logic              guard;
    logic              rnd;
    logic              sticky;
    logic              inexact;
    logic              inc;
    logic [SIG_W:0]    mant_inc;
    logic              carry;
    exp_t              exp_adj;
    logic [FRAC_W-1:0] frac;

    assign mant    = in.sig[SIG_W+2:3];
    assign guard   = in.sig[2];
    assign rnd     = in.sig[1];
    assign sticky  = in.sig[0];
    assign inexact = guard | rnd | sticky;

    // increment decision per rounding mode
    always_comb begin
        case (rm)
            RNE, RMM_AS_RNE: begin
                inc = guard & (rnd | sticky | mant[0]);     // ties go to even
            end
            RTZ: begin
                inc = 1'b0;
            end
            RDN: begin
                inc = in.sign & inexact;        // away from zero when negative
            end
            RUP: begin
                inc = ~in.sign & inexact;
            end
            default: begin
                inc = guard & (rnd | sticky | mant[0]);     // reserved codes as rne
            end
        endcase
    end

    assign mant_inc = {1'b0, mant} + (SIG_W+1)'(inc);
    assign carry    = mant_inc[SIG_W];     // 1.111..1 + 1 overflows

    // on carry the significand is 10.00..0, shift right and bump exponent
    assign frac    = carry ? mant_inc[FRAC_W:1] : mant_inc[FRAC_W-1:0];
    assign exp_adj = in.exp + exp_t'({9'd0, carry});

    // pack, zero always leaves as +0
    assign y = in.zero ? fp_word_t'(0) : {in.sign, exp_adj[EXP_W-1:0], frac};

endmodule

//--- hw/fpu_alu.sv
module fpu_alu (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  fpu_pkg::fpu_req_t req,
    output logic              rsp_valid,
    output fpu_pkg::fp_word_t rsp_y
);
    import fpu_pkg::*;

    logic       is_sub;
    prenorm_t   addsub_pre;
    logic       int_neg;
    fp_word_t   int_mag;
    prenorm_t   cvt_pre;
    prenorm_t   s1_d;
    prenorm_t   s1_q;
    stage_ctl_t s1_ctl;
    norm_t      s2_d;
    norm_t      s2_q;
    stage_ctl_t s2_ctl;
    fp_word_t   round_y;

    // stage 1: align and add/sub, or integer magnitude
    assign is_sub = (req.op == FSUB);

    fp_addsub u_addsub (
        .a      (req.a),
        .b      (req.b),
        .sub    (is_sub),
        .result (addsub_pre)
    );

    assign int_neg = req.a[31];
    assign int_mag = int_neg ? (~req.a + 32'd1) : req.a;   // 0x80000000 stays as 2^31

    // magnitude bit 31 lands on the hidden-bit position
    always_comb begin
        cvt_pre.sign = int_neg;
        cvt_pre.exp  = exp_t'(EXP_BIAS + 31);
        cvt_pre.sig  = {1'b0, int_mag, 2'b00};
        cvt_pre.zero = (req.a == '0);
    end

    always_comb begin
        case (req.op)
            FCVT_S_W: s1_d = cvt_pre;
            default:  s1_d = addsub_pre;
        endcase
    end

    // stage 2: normalize from the stage-1 register
    fp_normalize u_normalize (
        .in  (s1_q),
        .out (s2_d)
    );

    // stage 3: round from the stage-2 register
    fp_round u_round (
        .in (s2_q),
        .rm (s2_ctl.rm),
        .y  (round_y)
    );

    // data registers, only loaded behind a valid
    always_ff @(posedge clk) begin
        if (req_valid) begin
            s1_q <= s1_d;
        end
        if (s1_ctl.valid) begin
            s2_q <= s2_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_ctl    <= '0;
            s2_ctl    <= '0;
            rsp_valid <= 1'b0;
            rsp_y     <= '0;
        end else begin
            s1_ctl.valid <= req_valid;
            s1_ctl.rm    <= req.rm;     // rm rides along with the data
            s2_ctl       <= s1_ctl;
            rsp_valid    <= s2_ctl.valid;
            if (s2_ctl.valid) begin
                rsp_y <= round_y;       // hold last result otherwise
            end
        end
    end

endmodule

//--- testbench/clk_rst_gen.sv
module clk_rst_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;      // period 10
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;              // released on the second edge
    end

endmodule

//--- testbench/fpu_sva.sv
module fpu_sva (
    input logic              clk,
    input logic              rst_n,
    input logic              req_valid,
    input logic              rsp_valid,
    input fpu_pkg::fp_word_t rsp_y
);

    // one response per request, three edges later
    valid_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid == $past(req_valid, 3)
    ) else $error("rsp_valid does not follow req_valid by three cycles");

    quiet_in_reset: assert property (
        @(posedge clk)
        !rst_n |-> !rsp_valid
    ) else $error("rsp_valid high while in reset");

    // result register only loads together with rsp_valid
    y_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        !rsp_valid |-> $stable(rsp_y)
    ) else $error("rsp_y changed while rsp_valid was low");

endmodule

bind fpu_alu fpu_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .rsp_valid (rsp_valid),
    .rsp_y     (rsp_y)
);

//--- testbench/fpu_tb.sv
module fpu_tb;
    import fpu_pkg::*;

    localparam int          NUM_PATS       = 38;
    localparam int          LATENCY        = 3;     // drive edge to visible result
    localparam int          MAX_GAP        = 2;     // idle cycles between requests
    localparam int          MARGIN         = 20;
    localparam int          TIMEOUT_CYCLES = NUM_PATS * (1 + MAX_GAP) + LATENCY + MARGIN;
    localparam logic [31:0] SEED           = 32'd73863;

    // one line of the pattern file
    typedef struct packed {
        logic [3:0] op;
        logic [3:0] rm;
        fp_word_t   a;
        fp_word_t   b;
        fp_word_t   y;
    } pattern_t;

    typedef struct packed {
        int idx;
        int due;        // cycle in which the result must show
    } pending_t;

    logic     clk;
    logic     rst_n;
    logic     req_valid;
    fpu_req_t req;
    logic     rsp_valid;
    fp_word_t rsp_y;

    logic [$bits(pattern_t)-1:0] patterns [0:NUM_PATS-1];
    pending_t                    pend_q [$];
    int                          cycles = 0;

    clk_rst_gen u_clk_rst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fpu_alu dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_y     (rsp_y)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // mostly back to back, now and then one or two idle cycles
    function automatic int idle_gap(input logic [31:0] state);
        case (state[17:16])
            2'd2:    return 1;
            2'd3:    return 2;
            default: return 0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            cycles <= cycles + 1;       // counts only after reset
        end
    end

    // request driver
    initial begin
        pattern_t    pat;
        fpu_req_t    next_req;
        pending_t    entry;
        logic [31:0] lcg_state;
        int          gap;

        req_valid = 1'b0;
        req       = '0;
        lcg_state = SEED;
        $readmemh("testbench/fpu_patterns.hex", patterns);
        @(posedge rst_n);
        @(posedge clk);
        for (int i = 0; i < NUM_PATS; i++) begin
            lcg_state = lcg_next(lcg_state);
            gap = idle_gap(lcg_state);
            repeat (gap) begin
                req_valid <= 1'b0;
                @(posedge clk);
            end
            pat         = pattern_t'(patterns[i]);
            next_req.op = fpu_op_e'(pat.op);
            next_req.rm = round_mode_e'(pat.rm[2:0]);
            next_req.a  = pat.a;
            next_req.b  = pat.b;
            req         <= next_req;
            req_valid   <= 1'b1;
            entry.idx   = i;
            entry.due   = cycles + LATENCY;
            pend_q.push_back(entry);
            @(posedge clk);
        end
        req_valid <= 1'b0;
        while (pend_q.size() != 0) begin
            @(posedge clk);     // checker drains the queue on negedges
        end
        $display("All tests passed");
        $finish;
    end

    // response checker, samples away from the rising edge
    always @(negedge clk) begin
        pending_t head;
        pattern_t pat;
        fpu_op_e  op;
        string    name;

        if (rst_n) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("timeout after %0d cycles, %0d results still outstanding",
                         cycles, pend_q.size());
                $display("Some tests failed");
                $fatal(1, "timeout");
            end else if (rsp_valid && pend_q.size() == 0) begin
                $display("response %h arrived with no request outstanding", rsp_y);
                $display("Some tests failed");
                $fatal(1, "unexpected response");
            end else if (rsp_valid) begin
                head = pend_q.pop_front();
                pat  = pattern_t'(patterns[head.idx]);
                op   = fpu_op_e'(pat.op);
                name = $sformatf("pattern %0d %s", head.idx, op.name());
                check_value({name, " latency"}, head.due, cycles);
                check_value(name, pat.y, rsp_y);
            end else if (pend_q.size() != 0 && pend_q[0].due <= cycles) begin
                $display("no response for pattern %0d in cycle %0d",
                         pend_q[0].idx, pend_q[0].due);
                $display("Some tests failed");
                $fatal(1, "missing response");
            end
        end
    end

endmodule

//--- src.f
hw/fpu_pkg.sv
hw/fp_addsub.sv
hw/fp_normalize.sv
hw/fp_round.sv
hw/fpu_alu.sv
testbench/clk_rst_gen.sv
testbench/fpu_sva.sv
testbench/fpu_tb.sv

//--- run.sh
#!/bin/sh
# build the fpu testbench with verilator, run it and look for the pass line

verilator --binary --timing --assert --top-module fpu_tb -f src.f -o fpu_sim \
    && ./obj_dir/fpu_sim | tee /dev/stderr | grep -q "All tests passed" \
    || { echo "fpu simulation did not pass" >&2; exit 1; }

//--- testbench/fpu_patterns.hex
// columns: op (1 digit), rm (1 digit), a, b, expected y (8 digits each)
// op b fadd, c fsub, e fcvt.s.w; rm 0 rne, 1 rtz, 2 rdn, 3 rup, 7 rmm as rne
B03FC000003FC0000040400000
B33FC000003FC0000040400000
B03F8000003F80000140000000
B13F8000003F80000140000000
B33F8000003F80000140000001
B73F8000013F80000240000002
B13F8000013F80000240000001
B2BF800000BF800001C0000001
B3BF800000BF800001C0000000
B03F8000003F0000003FC00000
B33F800000308000003F800001
C03F8000003F80000000000000
C23F8000003F80000000000000
B03F800000BF80000000000000
C03F8000013F80000034000000
C03F8000003FC00000BF000000
B0BFC000003F800000BF000000
C03F800000BF80000040000000
C03F800000308000003F800000
C13F800000308000003F7FFFFF
E0000000000000000000000000
E000000001000000003F800000
E0FFFFFFFF00000000BF800000
E0FFFFFF9C00000000C2C80000
E08000000000000000CF000000
E000FFFFFF000000004B7FFFFF
E1FF00000100000000CB7FFFFF
E000123456000000004991A2B0
E001000001000000004B800000
E301000001000000004B800001
E001000003000000004B800002
E101000003000000004B800001
E701000005000000004B800002
E2FEFFFFFF00000000CB800001
E3FEFFFFFF00000000CB800000
E37FFFFFFF000000004F000000
E27FFFFFFF000000004EFFFFFF
E18000000100000000CEFFFFFF
